// ==== vlog.f ====
common/soc_pkg.sv
xbar/bus_arbiter.sv
xbar/bus_xbar.sv
hdl/boot_rom.sv
hdl/scratch_ram.sv
clint/clint.sv
hdl/debug_gate.sv
hdl/soc_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import soc_pkg::*; ();

  localparam int N_TXN     = 44 + 256 + 80 + 276 + 80 + 12;
  localparam int TXN_BOUND = 40;
  localparam int EXTRA_CYC = 1000;

  logic                     clk_i = 1'b0;
  logic                     ndmreset_n;
  logic                     rtc_i;
  logic     [N_MASTERS-1:0] mst_req_valid_i;
  bus_req_t [N_MASTERS-1:0] mst_req_i;
  logic     [N_MASTERS-1:0] mst_req_ready_o;
  logic     [N_MASTERS-1:0] mst_rsp_valid_o;
  bus_rsp_t [N_MASTERS-1:0] mst_rsp_o;
  logic     [N_MASTERS-1:0] mst_rsp_ready_i = '0;
  logic                     debug_req_i;
  logic                     timer_irq_o;
  logic                     ipi_o;
  logic                     debug_req_o;
  int                       check_cnt;
  int                       err_cnt;
  int                       pending;
  int                       last_checks;
  int                       last_errs;
  int                       extra_fail;

  always #2 clk_i = ~clk_i;

  soc_top UUT (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .rtc_i           ( rtc_i           ),
    .mst_req_valid_i ( mst_req_valid_i ),
    .mst_req_i       ( mst_req_i       ),
    .mst_req_ready_o ( mst_req_ready_o ),
    .mst_rsp_valid_o ( mst_rsp_valid_o ),
    .mst_rsp_o       ( mst_rsp_o       ),
    .mst_rsp_ready_i ( mst_rsp_ready_i ),
    .debug_req_i     ( debug_req_i     ),
    .timer_irq_o     ( timer_irq_o     ),
    .ipi_o           ( ipi_o           ),
    .debug_req_o     ( debug_req_o     )
  );

  tb_checker i_checker (
    .clk_i             ( clk_i           ),
    .ndmreset_n        ( ndmreset_n      ),
    .rtc_i             ( rtc_i           ),
    .mst_req_valid_i   ( mst_req_valid_i ),
    .mst_req_i         ( mst_req_i       ),
    .mst_req_ready_i   ( mst_req_ready_o ),
    .mst_rsp_valid_i   ( mst_rsp_valid_o ),
    .mst_rsp_i         ( mst_rsp_o       ),
    .mst_rsp_ready_i   ( mst_rsp_ready_i ),
    .debug_req_i       ( debug_req_i     ),
    .timer_irq_i       ( timer_irq_o     ),
    .ipi_i             ( ipi_o           ),
    .debug_req_gated_i ( debug_req_o     ),
    .check_cnt_o       ( check_cnt       ),
    .err_cnt_o         ( err_cnt         ),
    .pending_o         ( pending         )
  );

  // random back-pressure with ready low about a quarter of the time
  always @(negedge clk_i) begin
    if (!ndmreset_n) begin
      mst_rsp_ready_i = '0;
    end else begin
      mst_rsp_ready_i[0] = ($urandom % 4) != 0;
      mst_rsp_ready_i[1] = ($urandom % 4) != 0;
    end
  end

  // ----------------------------------------------------------------------
  // bus access helpers
  // ----------------------------------------------------------------------
  task automatic bus_xfer(input int k, input logic [ADDR_W-1:0] addr, input logic we,
                          input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
    @(negedge clk_i);
    mst_req_i[k].addr  = addr;
    mst_req_i[k].we    = we;
    mst_req_i[k].wdata = wdata;
    mst_req_i[k].be    = be;
    mst_req_valid_i[k] = 1'b1;
    do @(posedge clk_i); while (!mst_req_ready_o[k]);
    @(negedge clk_i);
    mst_req_valid_i[k] = 1'b0;
    do @(posedge clk_i); while (!(mst_rsp_valid_o[k] && mst_rsp_ready_i[k]));
  endtask

  function automatic logic [ADDR_W-1:0] rand_rom_addr();
    return ROM_BASE + 32'(($urandom % ROM_WORDS) * 4);
  endfunction

  function automatic logic [ADDR_W-1:0] rand_ram_addr();
    return RAM_BASE + 32'(($urandom % RAM_WORDS) * 4);
  endfunction

  task automatic random_op(input int k);
    if ($urandom % 3 == 0) begin
      bus_xfer(k, rand_rom_addr(), 1'b0, '0, 4'hF);
    end else begin
      bus_xfer(k, rand_ram_addr(), 1'($urandom), $urandom, 4'($urandom));
    end
  endtask

  function automatic logic mapped(input logic [ADDR_W-1:0] a);
    return (a - ROM_BASE < 32'(ROM_WORDS * 4)) || (a - RAM_BASE < 32'(RAM_WORDS * 4)) ||
           (a - CLINT_BASE < CLINT_SIZE);
  endfunction

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, check_cnt - last_checks,
             err_cnt - last_errs);
    last_checks = check_cnt;
    last_errs   = err_cnt;
  endtask

  task automatic rtc_pulse();
    repeat (2) @(negedge clk_i);
    rtc_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rtc_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [ADDR_W-1:0] a;
    void'($urandom(15867));
    ndmreset_n      = 1'b0;
    rtc_i           = 1'b0;
    debug_req_i     = 1'b1;
    mst_req_valid_i = '0;
    mst_req_i       = '0;
    last_checks     = 0;
    last_errs       = 0;
    extra_fail      = 0;
    repeat (8) @(negedge clk_i);
    ndmreset_n = 1'b1;

    repeat (40) bus_xfer(int'($urandom % 2), rand_rom_addr(), 1'b0, '0, 4'hF);
    repeat (4) bus_xfer(int'($urandom % 2), rand_rom_addr(), 1'b1, $urandom, 4'hF);
    report_test("rom");

    // fill pattern built from the full address
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = RAM_BASE + 32'(i * 4);
      bus_xfer(0, a, 1'b1, a ^ 32'hC3A5_0F96, 4'hF);
    end
    repeat (80) bus_xfer(int'($urandom % 2), rand_ram_addr(), 1'($urandom), $urandom,
                         4'($urandom));
    report_test("ram");

    repeat (20) begin
      do a = $urandom & 32'hFFFF_FFFC; while (mapped(a));
      bus_xfer(int'($urandom % 2), a, 1'($urandom), $urandom, 4'hF);
    end
    // every ram word read back after the unmapped accesses
    for (int i = 0; i < RAM_WORDS; i++) begin
      bus_xfer(0, RAM_BASE + 32'(i * 4), 1'b0, '0, 4'hF);
    end
    report_test("unmapped");

    fork
      repeat (40) random_op(0);
      repeat (40) random_op(1);
    join
    report_test("two masters");

    bus_xfer(0, CLINT_BASE + 32'(MSIP_OFS), 1'b1, 32'h1, 4'hF);
    repeat (6) @(negedge clk_i);
    bus_xfer(1, CLINT_BASE + 32'(MSIP_OFS), 1'b0, '0, 4'hF);
    bus_xfer(0, CLINT_BASE + 32'(MSIP_OFS), 1'b1, 32'h0, 4'hF);
    repeat (6) @(negedge clk_i);
    bus_xfer(0, CLINT_BASE + 32'(MTIME_LO_OFS), 1'b0, '0, 4'hF);
    repeat (10) rtc_pulse();
    repeat (12) @(negedge clk_i);
    bus_xfer(1, CLINT_BASE + 32'(MTIME_LO_OFS), 1'b0, '0, 4'hF);
    bus_xfer(1, CLINT_BASE + 32'(MTIME_HI_OFS), 1'b0, '0, 4'hF);
    bus_xfer(0, CLINT_BASE + 32'(MTIMECMP_HI_OFS), 1'b1, 32'h0, 4'hF);
    bus_xfer(0, CLINT_BASE + 32'(MTIMECMP_LO_OFS), 1'b1, 32'h3, 4'hF);
    repeat (8) @(negedge clk_i);
    bus_xfer(1, CLINT_BASE + 32'(MTIMECMP_HI_OFS), 1'b1, 32'hFFFF_0000, 4'hF);
    repeat (8) @(negedge clk_i);
    bus_xfer(1, CLINT_BASE + 32'(MTIMECMP_LO_OFS), 1'b0, '0, 4'hF);
    report_test("clint");

    repeat (20) begin
      @(negedge clk_i);
      debug_req_i = 1'($urandom);
    end
    repeat (4) @(negedge clk_i);
    report_test("debug gate");

    repeat (10) @(negedge clk_i);
    if (pending != 0) begin
      $display("%0d accepted requests never got a response", pending);
      extra_fail++;
    end
    $display("total: %0d checks, %0d errors", check_cnt, err_cnt + extra_fail);
    if (err_cnt == 0 && extra_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // limit scales with the number of bus transactions
  initial begin
    #((N_TXN * TXN_BOUND + EXTRA_CYC) * 4);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import soc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     rtc_i,
  input  logic     [N_MASTERS-1:0] mst_req_valid_i,
  input  bus_req_t [N_MASTERS-1:0] mst_req_i,
  input  logic     [N_MASTERS-1:0] mst_req_ready_i,
  input  logic     [N_MASTERS-1:0] mst_rsp_valid_i,
  input  bus_rsp_t [N_MASTERS-1:0] mst_rsp_i,
  input  logic     [N_MASTERS-1:0] mst_rsp_ready_i,
  input  logic                     debug_req_i,
  input  logic                     timer_irq_i,
  input  logic                     ipi_i,
  input  logic                     debug_req_gated_i,
  output int                       check_cnt_o,
  output int                       err_cnt_o,
  output int                       pending_o
);

  logic [DATA_W-1:0] ram_mdl [RAM_WORDS];
  logic [63:0]       cmp_mdl;
  logic              msip_mdl;
  bus_rsp_t          exp_q0 [$];
  bus_rsp_t          exp_q1 [$];
  int                rtc_pulses;
  int                rtc_quiet;
  int                since_wr;
  int                rel_cyc;
  logic              rtc_prev;
  logic              last_gnt;

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic hit(input logic [ADDR_W-1:0] a, input logic [ADDR_W-1:0] base,
                               input logic [ADDR_W-1:0] size);
    return (a >= base) && ((a - base) < size);
  endfunction

  // ----------------------------------------------------------------------
  // reference model of one access in acceptance order
  // ----------------------------------------------------------------------
  task automatic model_access(input bus_req_t r, output bus_rsp_t rsp);
    logic [15:0] ofs;
    logic [63:0] mtime_now;
    int          idx;
    rsp.err   = 1'b0;
    rsp.rdata = '0;
    mtime_now = 64'(rtc_pulses / 2);
    ofs       = r.addr[15:0] & 16'hFFFC;
    if (hit(r.addr, ROM_BASE, 32'(ROM_WORDS * 4))) begin
      idx = int'((r.addr - ROM_BASE) >> 2);
      if (r.we) begin
        rsp.err = 1'b1;
      end else begin
        rsp.rdata = BOOT_MAGIC ^ {4{idx[7:0]}};
      end
    end else if (hit(r.addr, RAM_BASE, 32'(RAM_WORDS * 4))) begin
      idx       = int'((r.addr - RAM_BASE) >> 2);
      rsp.rdata = ram_mdl[idx];
      if (r.we) begin
        ram_mdl[idx] = merge_bytes(ram_mdl[idx], r.wdata, r.be);
      end
    end else if (hit(r.addr, CLINT_BASE, CLINT_SIZE)) begin
      since_wr = r.we ? -1 : since_wr;
      case (ofs)
        MSIP_OFS: begin
          rsp.rdata = {31'b0, msip_mdl};
          if (r.we && r.be[0]) msip_mdl = r.wdata[0];
        end
        MTIMECMP_LO_OFS: begin
          rsp.rdata = cmp_mdl[31:0];
          if (r.we) cmp_mdl[31:0] = merge_bytes(cmp_mdl[31:0], r.wdata, r.be);
        end
        MTIMECMP_HI_OFS: begin
          rsp.rdata = cmp_mdl[63:32];
          if (r.we) cmp_mdl[63:32] = merge_bytes(cmp_mdl[63:32], r.wdata, r.be);
        end
        MTIME_LO_OFS: rsp.rdata = mtime_now[31:0];
        MTIME_HI_OFS: rsp.rdata = mtime_now[63:32];
        default:      rsp.rdata = '0;
      endcase
    end else begin
      rsp.err = 1'b1;
    end
  endtask

  task automatic compare(input string what, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    check_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk_i or negedge ndmreset_n) begin
    bus_rsp_t exp;
    bus_rsp_t got;
    if (!ndmreset_n) begin
      cmp_mdl     = '1;
      msip_mdl    = 1'b0;
      rtc_pulses  = 0;
      rtc_quiet   = 0;
      since_wr    = 0;
      rel_cyc     = 0;
      rtc_prev    = 1'b0;
      last_gnt    = 1'b0;
      check_cnt_o = 0;
      err_cnt_o   = 0;
      pending_o   = 0;
    end else begin
      // settled interrupt lines against the model
      if (since_wr >= 3 && rtc_quiet >= 8) begin
        compare("timer_irq_o", 32'(timer_irq_i), 32'(64'(rtc_pulses / 2) >= cmp_mdl));
        compare("ipi_o", 32'(ipi_i), 32'(msip_mdl));
      end
      compare("debug_req_o", 32'(debug_req_gated_i),
              32'((rel_cyc >= int'(DBG_DELAY_CYCLES)) ? debug_req_i : 1'b0));
      rel_cyc = rel_cyc + 1;
      since_wr = since_wr + 1;

      // each response must match the oldest request of its own master
      for (int k = 0; k < N_MASTERS; k++) begin
        if (mst_rsp_valid_i[k] && mst_req_ready_i != '0) begin
          err_cnt_o++;
          $display("request ready raised while a response waits at %0t", $time);
        end
        if (mst_rsp_valid_i[k] && mst_rsp_ready_i[k]) begin
          got = mst_rsp_i[k];
          if ((k == 0 && exp_q0.size() == 0) || (k == 1 && exp_q1.size() == 0)) begin
            err_cnt_o++;
            $display("master %0d got a response it never asked for at %0t", k, $time);
          end else begin
            exp = (k == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
            compare($sformatf("master %0d rdata", k), got.rdata, exp.rdata);
            compare($sformatf("master %0d err", k), 32'(got.err), 32'(exp.err));
          end
        end
      end

      // request acceptance and round-robin on ties
      for (int k = 0; k < N_MASTERS; k++) begin
        if (mst_req_valid_i[k] && mst_req_ready_i[k]) begin
          if (&mst_req_valid_i) begin
            compare("tie winner", 32'(k), 32'(!last_gnt));
          end
          last_gnt = k[0];
          model_access(mst_req_i[k], exp);
          if (k == 0) exp_q0.push_back(exp);
          else exp_q1.push_back(exp);
        end
      end

      if (rtc_i && !rtc_prev) begin
        rtc_pulses = rtc_pulses + 1;
        rtc_quiet  = 0;
      end else begin
        rtc_quiet = rtc_quiet + 1;
      end
      rtc_prev  = rtc_i;
      pending_o = exp_q0.size() + exp_q1.size();
    end
  end

endmodule

// ==== hdl/soc_top.sv ====
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     rtc_i,
  input  logic     [N_MASTERS-1:0] mst_req_valid_i,
  input  bus_req_t [N_MASTERS-1:0] mst_req_i,
  output logic     [N_MASTERS-1:0] mst_req_ready_o,
  output logic     [N_MASTERS-1:0] mst_rsp_valid_o,
  output bus_rsp_t [N_MASTERS-1:0] mst_rsp_o,
  input  logic     [N_MASTERS-1:0] mst_rsp_ready_i,
  input  logic                     debug_req_i,
  output logic                     timer_irq_o,
  output logic                     ipi_o,
  output logic                     debug_req_o
);

  slv_req_t          rom_req;
  slv_req_t          ram_req;
  slv_req_t          clint_req;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] clint_rdata;

  // ----------------------------------------------------------------------
  // interconnect
  // ----------------------------------------------------------------------
  bus_xbar i_xbar (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .mst_req_valid_i ( mst_req_valid_i ),
    .mst_req_i       ( mst_req_i       ),
    .mst_req_ready_o ( mst_req_ready_o ),
    .mst_rsp_valid_o ( mst_rsp_valid_o ),
    .mst_rsp_o       ( mst_rsp_o       ),
    .mst_rsp_ready_i ( mst_rsp_ready_i ),
    .rom_req_o       ( rom_req         ),
    .ram_req_o       ( ram_req         ),
    .clint_req_o     ( clint_req       ),
    .rom_rdata_i     ( rom_rdata       ),
    .ram_rdata_i     ( ram_rdata       ),
    .clint_rdata_i   ( clint_rdata     )
  );

  // ----------------------------------------------------------------------
  // slaves
  // ----------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  scratch_ram i_scratch_ram (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .rdata_o ( ram_rdata )
  );

  clint i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // debug request held off after reset
  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== hdl/debug_gate.sv ====
`timescale 1ns/1ps

module debug_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DBG_CNT_W-1:0] cnt_q;

  // window lets the boot code run before any halt request
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DBG_CNT_W'(DBG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

// ==== clint/clint.sv ====
`timescale 1ns/1ps

module clint import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  slv_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_rise;
  logic        half_q;
  logic        tick;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        timer_irq_q;
  logic [15:0] ofs;
  logic        wr_en;

  function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old_w,
                                              input logic [DATA_W-1:0] new_w,
                                              input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // rtc sync and divide by two
  // ----------------------------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // count only every second rising edge
  assign tick     = rtc_rise & half_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      half_q     <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        half_q <= ~half_q;
      end
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  assign ofs   = {req_i.idx, 2'b00};
  assign wr_en = req_i.req & req_i.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      // bus writes take priority over the tick
      if (wr_en) begin
        case (ofs)
          MSIP_OFS:        if (req_i.be[0]) msip_q <= req_i.wdata[0];
          MTIMECMP_LO_OFS: mtimecmp_q[31:0]  <= merge(mtimecmp_q[31:0], req_i.wdata, req_i.be);
          MTIMECMP_HI_OFS: mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], req_i.wdata, req_i.be);
          MTIME_LO_OFS:    mtime_q[31:0]     <= merge(mtime_q[31:0], req_i.wdata, req_i.be);
          MTIME_HI_OFS:    mtime_q[63:32]    <= merge(mtime_q[63:32], req_i.wdata, req_i.be);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      case (ofs)
        MSIP_OFS:        rdata_o <= {31'b0, msip_q};
        MTIMECMP_LO_OFS: rdata_o <= mtimecmp_q[31:0];
        MTIMECMP_HI_OFS: rdata_o <= mtimecmp_q[63:32];
        MTIME_LO_OFS:    rdata_o <= mtime_q[31:0];
        MTIME_HI_OFS:    rdata_o <= mtime_q[63:32];
        default:         rdata_o <= '0;
      endcase
    end
  end

  // interrupts
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

// ==== hdl/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import soc_pkg::*; (
  input  logic              clk_i,
  input  slv_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]    mem_q [RAM_WORDS];
  logic [RAM_IDX_W-1:0] widx;

  assign widx = req_i.idx[RAM_IDX_W-1:0];

  // read before write, so a write hands back the old word
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= mem_q[widx];
      if (req_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[widx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== hdl/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
  input  logic              clk_i,
  input  slv_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]    rom_table [ROM_WORDS];
  logic [ROM_IDX_W-1:0] ridx;

  // table filled from the shared rule
  for (genvar i = 0; i < ROM_WORDS; i++) begin : g_rom
    assign rom_table[i] = rom_word(i);
  end

  assign ridx = req_i.idx[ROM_IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= rom_table[ridx];
    end
  end

endmodule

// ==== xbar/bus_xbar.sv ====
`timescale 1ns/1ps

module bus_xbar import soc_pkg::*; (
  input  logic                           clk_i,
  input  logic                           ndmreset_n,
  input  logic     [N_MASTERS-1:0]       mst_req_valid_i,
  input  bus_req_t [N_MASTERS-1:0]       mst_req_i,
  output logic     [N_MASTERS-1:0]       mst_req_ready_o,
  output logic     [N_MASTERS-1:0]       mst_rsp_valid_o,
  output bus_rsp_t [N_MASTERS-1:0]       mst_rsp_o,
  input  logic     [N_MASTERS-1:0]       mst_rsp_ready_i,
  output slv_req_t                       rom_req_o,
  output slv_req_t                       ram_req_o,
  output slv_req_t                       clint_req_o,
  input  logic     [DATA_W-1:0]          rom_rdata_i,
  input  logic     [DATA_W-1:0]          ram_rdata_i,
  input  logic     [DATA_W-1:0]          clint_rdata_i
);

  xbar_state_e          state_q, state_d;
  logic [N_MASTERS-1:0] gnt;
  logic [N_MASTERS-1:0] owner_q;
  slave_sel_e           sel, sel_q;
  bus_req_t             greq;
  bus_rsp_t             rsp;
  logic                 accept;
  logic                 rsp_done;

  function automatic logic in_range(input logic [ADDR_W-1:0] addr,
                                    input logic [ADDR_W-1:0] base,
                                    input logic [ADDR_W-1:0] size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  function automatic slv_req_t mk_req(input logic hit, input bus_req_t r,
                                      input logic [ADDR_W-1:0] base);
    slv_req_t          s;
    logic [ADDR_W-1:0] ofs;
    ofs     = r.addr - base;
    s.req   = hit;
    s.we    = r.we;
    s.idx   = ofs[IDX_W+1:2];
    s.wdata = r.wdata;
    s.be    = r.be;
    return s;
  endfunction

  bus_arbiter i_arbiter (
    .clk_i      ( clk_i           ),
    .ndmreset_n ( ndmreset_n      ),
    .req_i      ( mst_req_valid_i ),
    .accept_i   ( accept          ),
    .gnt_o      ( gnt             )
  );

  // ----------------------------------------------------------------------
  // request side
  // ----------------------------------------------------------------------
  assign accept          = (state_q == XB_IDLE) && (|gnt);
  assign mst_req_ready_o = (state_q == XB_IDLE) ? gnt : '0;

  always_comb begin
    greq = '0;
    for (int k = 0; k < N_MASTERS; k++) begin
      if (gnt[k]) begin
        greq = mst_req_i[k];
      end
    end
  end

  // rom is read only, writes fall through to the error path
  always_comb begin
    if (in_range(greq.addr, ROM_BASE, ROM_WORDS * 4)) begin
      sel = greq.we ? SLV_NONE : SLV_ROM;
    end else if (in_range(greq.addr, RAM_BASE, RAM_WORDS * 4)) begin
      sel = SLV_RAM;
    end else if (in_range(greq.addr, CLINT_BASE, CLINT_SIZE)) begin
      sel = SLV_CLINT;
    end else begin
      sel = SLV_NONE;
    end
  end

  assign rom_req_o   = mk_req(accept && (sel == SLV_ROM), greq, ROM_BASE);
  assign ram_req_o   = mk_req(accept && (sel == SLV_RAM), greq, RAM_BASE);
  assign clint_req_o = mk_req(accept && (sel == SLV_CLINT), greq, CLINT_BASE);

  // ----------------------------------------------------------------------
  // response side
  // ----------------------------------------------------------------------
  assign rsp_done = (state_q == XB_RESP) && (|(owner_q & mst_rsp_ready_i));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      XB_IDLE: if (accept) state_d = XB_RESP;
      XB_RESP: if (rsp_done) state_d = XB_IDLE;
      default: state_d = XB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= XB_IDLE;
      owner_q <= '0;
      sel_q   <= SLV_NONE;
    end else begin
      state_q <= state_d;
      if (accept) begin
        owner_q <= gnt;
        sel_q   <= sel;
      end
    end
  end

  // slaves hold their read word until the next request
  always_comb begin
    rsp.err = (sel_q == SLV_NONE);
    unique case (sel_q)
      SLV_ROM:   rsp.rdata = rom_rdata_i;
      SLV_RAM:   rsp.rdata = ram_rdata_i;
      SLV_CLINT: rsp.rdata = clint_rdata_i;
      default:   rsp.rdata = '0;
    endcase
  end

  assign mst_rsp_valid_o = (state_q == XB_RESP) ? owner_q : '0;
  assign mst_rsp_o       = {N_MASTERS{rsp}};

endmodule

// ==== xbar/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic [N_MASTERS-1:0] req_i,
  input  logic                 accept_i,
  output logic [N_MASTERS-1:0] gnt_o
);

  logic [MST_IDX_W-1:0] last_q;
  logic [MST_IDX_W-1:0] gnt_idx;

  // search starts one past the last winner
  always_comb begin
    int unsigned cand;
    logic        found;
    gnt_o   = '0;
    gnt_idx = last_q;
    found   = 1'b0;
    for (int unsigned k = 1; k <= N_MASTERS; k++) begin
      cand = (int'(last_q) + k) % N_MASTERS;
      if (!found && req_i[cand]) begin
        gnt_o[cand] = 1'b1;
        gnt_idx     = MST_IDX_W'(cand);
        found       = 1'b1;
      end
    end
  end

  // master 0 counts as last granted out of reset
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      last_q <= '0;
    end else if (accept_i) begin
      last_q <= gnt_idx;
    end
  end

endmodule

// ==== common/soc_pkg.sv ====
package soc_pkg;

  // ----------------------------------------------------------------------
  // widths and counts
  // ----------------------------------------------------------------------
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = 4;
  localparam int unsigned N_MASTERS  = 2;
  localparam int unsigned MST_IDX_W  = $clog2(N_MASTERS);
  // word index wide enough for the 64 KiB CLINT window
  localparam int unsigned IDX_W      = 14;

  // ----------------------------------------------------------------------
  // address map
  // ----------------------------------------------------------------------
  localparam logic [ADDR_W-1:0] ROM_BASE   = 32'h0000_1000;
  localparam int unsigned       ROM_WORDS  = 64;
  localparam int unsigned       ROM_IDX_W  = $clog2(ROM_WORDS);
  localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h8000_0000;
  localparam int unsigned       RAM_WORDS  = 256;
  localparam int unsigned       RAM_IDX_W  = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_SIZE = 32'h0001_0000;

  // clint register offsets
  localparam logic [15:0] MSIP_OFS        = 16'h0000;
  localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
  localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
  localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8;
  localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

  localparam logic [DATA_W-1:0] BOOT_MAGIC       = 32'h5A3C_96E1;
  localparam int unsigned       DBG_DELAY_CYCLES = 64;
  localparam int unsigned       DBG_CNT_W        = $clog2(DBG_DELAY_CYCLES + 1);

  // ----------------------------------------------------------------------
  // bus types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } slv_req_t;

  typedef enum logic [1:0] {SLV_ROM, SLV_RAM, SLV_CLINT, SLV_NONE} slave_sel_e;
  typedef enum logic {XB_IDLE, XB_RESP} xbar_state_e;

  // boot rom contents: magic xor the index in every byte
  function automatic logic [DATA_W-1:0] rom_word(input int unsigned i);
    logic [7:0] b;
    b = i[7:0];
    return BOOT_MAGIC ^ {4{b}};
  endfunction

endpackage
